// ==== bench/dfpToIntTb.sv ====
`include "dfpConv_params.svh"

module dfpToIntTb;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int IN_RANGE_TESTS = 300;
	localparam int STALL_TESTS = 20;
	// rounding 6, saturation 6, zero 4, restart 1
	localparam int DIRECTED_TESTS = 17;
	localparam int NUM_TESTS = IN_RANGE_TESTS + STALL_TESTS + DIRECTED_TESTS + 1;
	localparam int CYCLE_LIMIT = NUM_TESTS * 30 + 100;
	// edges from the ld edge to done
	localparam int LATENCY = 22;

	logic clk = 1'b0;
	logic rst;
	logic ce;
	logic ld;
	logic op;
	logic [`DFP_WIDTH-1:0] i;
	logic [`INT_WIDTH-1:0] o;
	logic overflow;
	logic done;

	int cycleCount = 0;
	int testCount = 0;
	int passCount = 0;
	int failCount = 0;
	int errs;
	logic [`SIG_WIDTH-1:0] sig;

	dfpToInt i_dut (
		.clk(clk),
		.rst(rst),
		.ce(ce),
		.ld(ld),
		.op(op),
		.i(i),
		.o(o),
		.overflow(overflow),
		.done(done)
	);

	always #10 clk = ~clk;

	// hard stop for a hung run
	always @(posedge clk) begin
		cycleCount <= cycleCount + 1;
		if (cycleCount >= CYCLE_LIMIT) begin
			$display("timeout: run went past %0d cycles", CYCLE_LIMIT);
			$display(">>> FAIL");
			$finish;
		end
	end

	// ============================================================
	// operand helpers
	// ============================================================

	function automatic logic [`SIG_WIDTH-1:0] randomDigits();
		logic [`SIG_WIDTH-1:0] s;
		for (int n = 0; n < `SIG_DIGITS; n++) begin
			s[n*4 +: 4] = 4'($urandom_range(0, 9));
		end
		return s;
	endfunction

	// digit n counts from 1 at the top nibble
	function automatic logic [`SIG_WIDTH-1:0] withDigit(input logic [`SIG_WIDTH-1:0] s,
			input int n, input logic [3:0] v);
		s[`SIG_WIDTH - 4*n +: 4] = v;
		return s;
	endfunction

	function automatic logic [`DFP_WIDTH-1:0] buildOperand(input logic sign, input int k,
			input logic [`SIG_WIDTH-1:0] s);
		return {sign, 11'(`EXP_BIAS + k), s};
	endfunction

	// mostly -2..21 and sometimes far out on either side
	function automatic int randomK();
		int r;
		r = int'($urandom_range(0, 9));
		if (r == 0) begin
			return int'($urandom_range(22, 900));
		end else if (r == 1) begin
			return -int'($urandom_range(3, 1000));
		end
		return int'($urandom_range(0, 23)) - 2;
	endfunction

	// ============================================================
	// reference model
	// ============================================================

	function automatic void refModel(input logic [`DFP_WIDTH-1:0] opnd, input logic mode,
			output logic [`INT_WIDTH-1:0] expO, output logic expOvf);
		logic sign;
		int k;
		logic big;
		logic [71:0] mag;
		logic [71:0] maxPos;
		sign = opnd[`DFP_WIDTH-1];
		k = int'(opnd[`DFP_WIDTH-2 -: `EXP_WIDTH]) - `EXP_BIAS;
		big = 1'b0;
		mag = '0;
		maxPos = (72'd1 << 63) - 72'd1;
		if (opnd[`SIG_WIDTH-1:0] == '0) begin
			mag = '0;
		end else if (k == 0) begin
			mag = (opnd[`SIG_WIDTH-4 +: 4] >= 4'd5) ? 72'd1 : 72'd0;
		end else if (k > 19) begin
			big = 1'b1;
		end else if (k > 0) begin
			for (int n = 1; n <= k; n++) begin
				mag = mag * 72'd10 + 72'(opnd[`SIG_WIDTH - 4*n +: 4]);
			end
			// half up on the first dropped digit
			if (opnd[`SIG_WIDTH - 4*(k+1) +: 4] >= 4'd5) begin
				mag = mag + 72'd1;
			end
		end
		if (!mode) begin
			expOvf = sign ? (big || mag != '0) : big;
			expO = (sign || !big) ? (sign ? '0 : mag[63:0]) : '1;
		end else if (big || mag > maxPos) begin
			expOvf = 1'b1;
			expO = sign ? -maxPos[63:0] : maxPos[63:0];
		end else begin
			expOvf = 1'b0;
			expO = sign ? -mag[63:0] : mag[63:0];
		end
	endfunction

	// ============================================================
	// drivers and checks
	// ============================================================

	task automatic issueLd(input logic [`DFP_WIDTH-1:0] opnd, input logic mode);
		@(posedge clk);
		ce <= 1'b1;
		ld <= 1'b1;
		i <= opnd;
		op <= mode;
		@(posedge clk);
		// scramble the inputs since the DUT holds its own copy
		ld <= 1'b0;
		i <= {$urandom, $urandom, $urandom};
		op <= ~mode;
	endtask

	task automatic reportTest(input string name, input int n);
		testCount++;
		if (n == 0) begin
			passCount++;
			$display("test %0d %s: ok", testCount, name);
		end else begin
			failCount++;
			$display("test %0d %s: %0d errors", testCount, name, n);
		end
	endtask

	task automatic checkConversion(input string name, input logic [`DFP_WIDTH-1:0] opnd,
			input logic mode, input int stallBudget);
		logic [`INT_WIDTH-1:0] expO;
		logic expOvf;
		int edges;
		int stalled;
		int n;
		n = 0;
		edges = 0;
		stalled = 0;
		refModel(opnd, mode, expO, expOvf);
		issueLd(opnd, mode);
		@(negedge clk);
		if (done !== 1'b0) begin
			$display("** Error at %0d ns: done = %b, expected 0 after ld", $time, done);
			n++;
		end
		while (done !== 1'b1 && edges < 3 * LATENCY) begin
			@(posedge clk);
			edges++;
			// ce as the DUT saw it on this edge
			if (!ce) begin
				stalled++;
			end
			if (stallBudget > 0 && $urandom_range(0, 2) == 0) begin
				ce <= 1'b0;
				stallBudget--;
			end else begin
				ce <= 1'b1;
			end
			@(negedge clk);
		end
		if (done !== 1'b1) begin
			$display("done never rose within %0d edges of ld", edges);
			n++;
		end else if (edges != LATENCY + stalled) begin
			$display("** Error at %0d ns: done latency = %0d, expected %0d", $time, edges,
				LATENCY + stalled);
			n++;
		end
		if (o !== expO) begin
			$display("** Error at %0d ns: o = %h, expected %h", $time, o, expO);
			n++;
		end
		if (overflow !== expOvf) begin
			$display("** Error at %0d ns: overflow = %b, expected %b", $time, overflow, expOvf);
			n++;
		end
		reportTest(name, n);
	endtask

	// ============================================================
	// test sequence
	// ============================================================

	initial begin
		rst = 1'b1;
		ce = 1'b1;
		ld = 1'b0;
		op = 1'b0;
		i = '0;
		void'($urandom(32'h31cc));
		repeat (2) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		errs = 0;
		if (done !== 1'b0) begin
			$display("** Error at %0d ns: done = %b, expected 0", $time, done);
			errs++;
		end
		if (overflow !== 1'b0) begin
			$display("** Error at %0d ns: overflow = %b, expected 0", $time, overflow);
			errs++;
		end
		if (o !== '0) begin
			$display("** Error at %0d ns: o = %h, expected 0", $time, o);
			errs++;
		end
		reportTest("reset", errs);

		// signed keeps to 18 digits so nothing saturates
		for (int t = 0; t < IN_RANGE_TESTS; t++) begin
			if (t % 2 == 1) begin
				checkConversion("in-range signed", buildOperand(1'($urandom),
					int'($urandom_range(1, 18)), randomDigits()), 1'b1, 0);
			end else begin
				checkConversion("in-range unsigned", buildOperand(1'b0,
					int'($urandom_range(1, 19)), randomDigits()), 1'b0, 0);
			end
		end

		checkConversion("round down", buildOperand(1'b0, 5, withDigit(randomDigits(), 6, 4)),
			1'b0, 0);
		checkConversion("round up", buildOperand(1'b1, 5, withDigit(randomDigits(), 6, 5)),
			1'b1, 0);
		checkConversion("half", buildOperand(1'b1, 0, withDigit(randomDigits(), 1, 7)), 1'b1, 0);
		checkConversion("below half", buildOperand(1'b0, 0, withDigit(randomDigits(), 1, 3)),
			1'b0, 0);
		checkConversion("small", buildOperand(1'b0, -1, withDigit(randomDigits(), 1, 9)),
			1'b1, 0);
		checkConversion("all nines", buildOperand(1'b0, 19, {`SIG_DIGITS{4'h9}}), 1'b0, 0);

		checkConversion("big unsigned", buildOperand(1'b0, 25, randomDigits()), 1'b0, 0);
		checkConversion("big signed pos", buildOperand(1'b0, 20, randomDigits()), 1'b1, 0);
		checkConversion("big signed neg", buildOperand(1'b1, 40, randomDigits()), 1'b1, 0);
		sig = withDigit(withDigit(randomDigits(), 1, 9), 2, 9);
		checkConversion("signed over max", buildOperand(1'b0, 19, sig), 1'b1, 0);
		checkConversion("neg unsigned", buildOperand(1'b1, 5, withDigit(randomDigits(), 1, 3)),
			1'b0, 0);
		checkConversion("neg big unsigned", buildOperand(1'b1, 30, randomDigits()), 1'b0, 0);

		checkConversion("zero", buildOperand(1'b0, 30, '0), 1'b0, 0);
		checkConversion("zero", buildOperand(1'b1, 3, '0), 1'b1, 0);
		checkConversion("zero", buildOperand(1'b1, -5, '0), 1'b0, 0);
		checkConversion("zero", buildOperand(1'b0, 19, '0), 1'b1, 0);

		// abandon a conversion halfway so only the second one may show up
		issueLd(buildOperand(1'b0, 10, randomDigits()), 1'b0);
		repeat (8) @(posedge clk);
		checkConversion("restart", buildOperand(1'b1, 12, randomDigits()), 1'b1, 0);

		for (int t = 0; t < STALL_TESTS; t++) begin
			checkConversion("stall", buildOperand(1'($urandom), randomK(), randomDigits()),
				1'($urandom), 1 + int'($urandom_range(0, 4)));
		end

		$display("%0d tests, %0d passed, %0d failed", testCount, passCount, failCount);
		if (failCount == 0) begin
			$display(">>> PASS");
		end else begin
			$display(">>> FAIL");
		end
		$finish;
	end

endmodule

// ==== dfpToInt.f ====
+incdir+source
source/dfpPkg.sv
source/bcdConvIf.sv
source/dfpUnpack.sv
source/digitAligner.sv
source/bcdToBin.sv
source/dfpToInt.sv
bench/dfpToIntTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
set -e -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
	--top-module dfpToIntTb \
	-f dfpToInt.f \
	--Mdir build \
	-o dfpToIntSim

./build/dfpToIntSim | tee sim.log

if grep -q ">>> FAIL" sim.log; then
	echo "simulation failed, see sim.log"
	exit 1
fi

echo "simulation passed"

// ==== source/bcdConvIf.sv ====
`include "dfpConv_params.svh"

// link between the converter top and the BCD to binary engine
interface bcdConvIf;

	// clock enable, stalls the engine together with the top
	logic ce;
	// one cycle pulse, restarts the engine even mid conversion
	logic start;
	// aligned digits, most significant digit in the top nibble
	logic [`BCD_WIDTH-1:0] bcd;
	// binary value, valid while done is high
	logic [`INT_WIDTH-1:0] bin;
	// level, falls on start
	logic done;

	modport ctrl (
		output ce,
		output start,
		output bcd,
		input bin,
		input done
	);

	modport conv (
		input ce,
		input start,
		input bcd,
		output bin,
		output done
	);

endinterface

// ==== source/bcdToBin.sv ====
`include "dfpConv_params.svh"

module bcdToBin (
	input logic clk,
	input logic rst,
	bcdConvIf.conv b2b
);
	import dfpPkg::*;

	b2bState state;
	// digits still to be consumed, msd on top
	logic [`BCD_WIDTH-1:0] digits;
	// running binary value
	logic [`INT_WIDTH-1:0] acc;
	// digits consumed so far
	logic [4:0] digitCnt;
	logic [3:0] curDigit;

	assign curDigit = digits[`BCD_WIDTH-1 -: 4];

	// ============================================================
	// sequencer
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= B2B_IDLE;
			digitCnt <= '0;
		end else if (b2b.ce) begin
			// start restarts from any state
			if (b2b.start) begin
				state <= B2B_RUN;
				digitCnt <= '0;
			end else begin
				case (state)
					B2B_RUN: begin
						digitCnt <= digitCnt + 5'd1;
						// last digit goes in on this edge
						if (digitCnt == 5'(`INT_DIGITS - 1)) begin
							state <= B2B_DONE;
						end
					end
					// idle and done just hold
					default: state <= state;
				endcase
			end
		end
	end

	// ============================================================
	// datapath
	// ============================================================

	always_ff @(posedge clk) begin
		if (b2b.ce) begin
			if (b2b.start) begin
				digits <= b2b.bcd;
				acc <= '0;
			end else if (state == B2B_RUN) begin
				// acc * 10 as acc * 8 + acc * 2, then add the digit
				acc <= (acc << 3) + (acc << 1) + {{(`INT_WIDTH - 4){1'b0}}, curDigit};
				digits <= digits << 4;
			end
		end
	end

	assign b2b.bin = acc;
	assign b2b.done = state == B2B_DONE;

	// every digit that enters the accumulator must be decimal
	assert property (@(posedge clk) disable iff (rst)
		(b2b.ce && !b2b.start && state == B2B_RUN) |-> curDigit <= 4'd9)
	else $error("bcdToBin: non decimal digit %0h consumed", curDigit);

endmodule

// ==== source/dfpConv_params.svh ====
`ifndef DFPCONV_PARAMS_SVH
`define DFPCONV_PARAMS_SVH

// ============================================================
// operand format
// ============================================================

// sign, biased exponent, BCD significand packed msb first
`define DFP_WIDTH 96
`define EXP_WIDTH 11
// exponent at which the significand reads as 0.d1d2...d21
`define EXP_BIAS 1023
`define SIG_DIGITS 21
`define SIG_WIDTH (`SIG_DIGITS * 4)

// ============================================================
// integer result
// ============================================================

// 19 integer digits plus one for the rounding carry
`define INT_DIGITS 20
`define BCD_WIDTH (`INT_DIGITS * 4)
`define INT_WIDTH 64

`endif

// ==== source/dfpPkg.sv ====
`include "dfpConv_params.svh"

package dfpPkg;

	// unpacked operand, field order matches the packed format
	typedef struct packed {
		logic sign;
		logic [`EXP_WIDTH-1:0] exp;
		// d1 sits in the top nibble
		logic [`SIG_WIDTH-1:0] sig;
	} dfpUnpacked;

	// encoding follows the op pin: 1 = signed
	typedef enum logic {
		MODE_UNSIGNED = 1'b0,
		MODE_SIGNED = 1'b1
	} convMode;

	// operand class as seen by the result select
	typedef enum logic [2:0] {
		CLS_ZERO,
		CLS_SMALL,
		CLS_HALF,
		CLS_NORMAL,
		CLS_BIG
	} opClass;

	// iterative BCD to binary sequencer
	typedef enum logic [1:0] {
		B2B_IDLE,
		B2B_RUN,
		B2B_DONE
	} b2bState;

	localparam logic signed [`EXP_WIDTH+1:0] EXP_BIAS_S = `EXP_BIAS;

	// number of integer digits k = exp - bias, two extra bits keep the sign
	function automatic logic signed [`EXP_WIDTH+1:0] intDigitCount(
		input logic [`EXP_WIDTH-1:0] exp
	);
		return $signed({2'b00, exp}) - EXP_BIAS_S;
	endfunction

endpackage

// ==== source/dfpToInt.sv ====
`include "dfpConv_params.svh"

module dfpToInt (
	input logic clk,
	input logic rst,
	input logic ce,
	input logic ld,
	// 1 = signed, 0 = unsigned
	input logic op,
	input logic [`DFP_WIDTH-1:0] i,
	output logic [`INT_WIDTH-1:0] o,
	output logic overflow,
	output logic done
);
	import dfpPkg::*;

	// largest signed value, 2^63 - 1
	localparam logic [`INT_WIDTH-1:0] MAX_POS = {1'b0, {(`INT_WIDTH - 1){1'b1}}};

	logic [`DFP_WIDTH-1:0] opndReg;
	convMode modeReg;
	logic startReg;

	dfpUnpacked unp;
	opClass cls;
	logic [`BCD_WIDTH-1:0] alignedDigits;
	logic roundCarry;

	// result select
	logic isSigned;
	logic tooBig;
	logic [`INT_WIDTH-1:0] magnitude;
	logic [`INT_WIDTH-1:0] resultComb;
	logic ovfComb;

	bcdConvIf b2bBus ();

	// ============================================================
	// operand capture and start
	// ============================================================

	// inputs only need to be valid on the ld edge
	always_ff @(posedge clk) begin
		if (ce && ld) begin
			opndReg <= i;
			modeReg <= convMode'(op);
		end
	end

	dfpUnpack uUnpack (
		.opnd(opndReg),
		.unp(unp),
		.cls(cls)
	);

	digitAligner uAlign (
		.unp(unp),
		.intDigits(alignedDigits),
		.roundCarry(roundCarry)
	);

	// aligned digits stay put until the next ld, so bcd is stable through the run
	assign b2bBus.ce = ce;
	assign b2bBus.start = startReg;
	assign b2bBus.bcd = alignedDigits;

	bcdToBin uB2b (
		.clk(clk),
		.rst(rst),
		.b2b(b2bBus.conv)
	);

	// ============================================================
	// saturation and sign
	// ============================================================

	assign isSigned = modeReg == MODE_SIGNED;

	always_comb begin
		magnitude = b2bBus.bin;
		tooBig = 1'b0;
		case (cls)
			CLS_ZERO, CLS_SMALL: magnitude = '0;
			// 0.5 .. 0.99 rounds to one
			CLS_HALF: magnitude = {{(`INT_WIDTH - 1){1'b0}}, 1'b1};
			CLS_BIG: tooBig = 1'b1;
			// 19 digits always fit unsigned, even 10^19 after rounding
			default: tooBig = isSigned && (roundCarry || b2bBus.bin > MAX_POS);
		endcase
	end

	always_comb begin
		if (!isSigned && unp.sign && (tooBig || magnitude != '0)) begin
			// negative in unsigned mode, also when the value is huge
			resultComb = '0;
			ovfComb = 1'b1;
		end else if (tooBig) begin
			ovfComb = 1'b1;
			if (!isSigned) begin
				resultComb = '1;
			end else if (unp.sign) begin
				resultComb = -MAX_POS;
			end else begin
				resultComb = MAX_POS;
			end
		end else begin
			ovfComb = 1'b0;
			resultComb = (isSigned && unp.sign) ? -magnitude : magnitude;
		end
	end

	// ============================================================
	// output register
	// ============================================================

	always_ff @(posedge clk) begin
		if (rst) begin
			startReg <= 1'b0;
			done <= 1'b0;
			o <= '0;
			overflow <= 1'b0;
		end else if (ce) begin
			// start goes out one edge after ld
			startReg <= ld;
			if (ld) begin
				done <= 1'b0;
			end else if (!startReg && b2bBus.done && !done) begin
				// engine done is stale while start is still pending
				o <= resultComb;
				overflow <= ovfComb;
				done <= 1'b1;
			end
		end
	end

	// a new start always follows the ld that cleared done
	assert property (@(posedge clk) disable iff (rst) !(done && startReg))
	else $error("dfpToInt: done and start high together");

	// result holds until the next ld
	assert property (@(posedge clk) disable iff (rst) (done && !ld) |=> $stable(o))
	else $error("dfpToInt: o changed while done was high");

endmodule

// ==== source/dfpUnpack.sv ====
`include "dfpConv_params.svh"

module dfpUnpack (
	input logic [`DFP_WIDTH-1:0] opnd,
	output dfpPkg::dfpUnpacked unp,
	output dfpPkg::opClass cls
);
	import dfpPkg::*;

	// k, the count of digits left of the decimal point
	logic signed [`EXP_WIDTH+1:0] digitCount;
	// first significand digit, decides the half class
	logic [3:0] leadDigit;

	// ============================================================
	// field split
	// ============================================================

	assign unp.sign = opnd[`DFP_WIDTH-1];
	assign unp.exp = opnd[`DFP_WIDTH-2 -: `EXP_WIDTH];
	assign unp.sig = opnd[`SIG_WIDTH-1:0];

	assign leadDigit = unp.sig[`SIG_WIDTH-1 -: 4];

	// ============================================================
	// classification
	// ============================================================

	always_comb begin
		digitCount = intDigitCount(unp.exp);
		// zero wins over any exponent
		if (unp.sig == '0) begin
			cls = CLS_ZERO;
		end else if (digitCount < 0) begin
			// at most 0.0d..., below one half
			cls = CLS_SMALL;
		end else if (digitCount == 0) begin
			// 0.d1... rounds to one only from 0.5 upward
			if (leadDigit >= 4'd5) begin
				cls = CLS_HALF;
			end else begin
				cls = CLS_SMALL;
			end
		end else if (digitCount <= `INT_DIGITS - 1) begin
			// 1 to 19 integer digits
			cls = CLS_NORMAL;
		end else begin
			// 20 digits or more never fit a signed 64 bit value
			cls = CLS_BIG;
		end
	end

endmodule

// ==== source/digitAligner.sv ====
`include "dfpConv_params.svh"

module digitAligner (
	input dfpPkg::dfpUnpacked unp,
	output logic [`BCD_WIDTH-1:0] intDigits,
	output logic roundCarry
);
	import dfpPkg::*;

	logic signed [`EXP_WIDTH+1:0] digitCount;
	// k clamped to 0..20, outside the normal class the digits are don't care
	logic [4:0] intCount;
	// digits dropped on the right, 1..21
	logic [4:0] dropCount;
	logic [`SIG_WIDTH-1:0] shifted;
	logic [`SIG_WIDTH-1:0] roundSrc;
	logic [`BCD_WIDTH-1:0] aligned;
	logic [3:0] roundDigit;
	logic roundUp;

	// true when every nibble is a decimal digit
	function automatic logic allDigitsValid(input logic [`SIG_WIDTH-1:0] v);
		logic ok;
		ok = 1'b1;
		for (int d = 0; d < `SIG_DIGITS; d++) begin
			if (v[d*4 +: 4] > 4'd9) begin
				ok = 1'b0;
			end
		end
		return ok;
	endfunction

	// ============================================================
	// digit shifter
	// ============================================================

	always_comb begin
		digitCount = intDigitCount(unp.exp);
		if (digitCount < 0) begin
			intCount = 5'd0;
		end else if (digitCount > `INT_DIGITS) begin
			intCount = 5'(`INT_DIGITS);
		end else begin
			intCount = digitCount[4:0];
		end
	end

	assign dropCount = 5'(`SIG_DIGITS) - intCount;

	// d1..dk land in the low k digit positions
	assign shifted = unp.sig >> {dropCount, 2'b00};
	assign aligned = shifted[`BCD_WIDTH-1:0];

	// d(k+1) is the first digit thrown away
	assign roundSrc = unp.sig >> {dropCount - 5'd1, 2'b00};
	assign roundDigit = roundSrc[3:0];
	// round half up
	assign roundUp = roundDigit >= 4'd5;

	// ============================================================
	// BCD increment
	// ============================================================

	always_comb begin
		logic carry;
		logic [4:0] digitSum;
		carry = roundUp;
		roundCarry = 1'b0;
		for (int d = 0; d < `INT_DIGITS; d++) begin
			digitSum = {1'b0, aligned[d*4 +: 4]} + {4'd0, carry};
			// decimal wrap, 9 + 1 gives 0 and carries on
			if (digitSum == 5'd10) begin
				intDigits[d*4 +: 4] = 4'd0;
				carry = 1'b1;
			end else begin
				intDigits[d*4 +: 4] = digitSum[3:0];
				carry = 1'b0;
			end
			// carry out of digit 19 means the result became 10^19
			if (d == `INT_DIGITS - 2) begin
				roundCarry = carry;
			end
		end
	end

	// decimal increment may never produce a nibble above 9
	always_comb begin
		if (allDigitsValid(unp.sig)) begin
			assert (allDigitsValid({4'd0, intDigits}))
			else $error("digitAligner: invalid BCD digit after rounding");
		end
	end

endmodule
